//--- sources.f
logic/lsu_pkg.sv
logic/lane_steer.sv
logic/req_fifo.sv
logic/apb_master.sv
logic/data_sram_apb.sv
logic/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := lsu_tb
FILELIST   := sources.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Done: errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/lsu_tb.sv
module lsu_tb import lsu_pkg::*; ();

	// fifo, setup, access, master register, extension register
	localparam int load_latency = 5;
	localparam int reset_cycles = 16;
	localparam logic [31:0] seed = 32'd74749;

	// one row of the stimulus table
	typedef struct packed {
		logic [2:0] test;
		access_e    access;
		addr_t      addr;
		word_t      data;
		word_t      exp_data;
	} entry_t;

	logic     clk;
	logic     reset;
	logic     req_valid;
	mem_req_t req;
	logic     req_ready;
	logic     rsp_valid;
	word_t    load_data;

	entry_t     stim [$];
	// loads on their way, oldest first
	entry_t     pending [$];
	// byte-wide reference of the 8 KiB data memory
	logic [7:0] ref_mem [8192];
	word_t      rng;
	int         cycle_count = 0;
	int         cycle_limit = 0;
	int         checks;
	int         errors;
	int         test_checks;
	int         test_errors;
	int         tests_run;
	logic       saw_stall;

	lsu_top i_lsu_top (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.load_data (load_data)
	);

	always #50 clk = ~clk;

	// run limit from the table length
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic is_load(input access_e acc);
		return acc >= acc_lbu;
	endfunction

	// little endian, byte lane n sits at byte address offset n
	task automatic model_store(input access_e acc, input addr_t addr, input word_t data);
		logic [12:0] a;
		a = addr[12:0];
		ref_mem[a] = data[7:0];
		if (acc != acc_sb) begin
			ref_mem[a + 13'd1] = data[15:8];
		end
		if (acc == acc_sw) begin
			ref_mem[a + 13'd2] = data[23:16];
			ref_mem[a + 13'd3] = data[31:24];
		end
	endtask

	function automatic word_t model_load(input access_e acc, input addr_t addr);
		logic [12:0] a;
		logic [7:0]  b0;
		logic [7:0]  b1;
		a  = addr[12:0];
		b0 = ref_mem[a];
		b1 = ref_mem[a + 13'd1];
		case (acc)
			acc_lbu: return {24'h000000, b0};
			acc_lb:  return {{24{b0[7]}}, b0};
			acc_lhu: return {16'h0000, b1, b0};
			acc_lh:  return {{16{b1[7]}}, b1, b0};
			default: return {ref_mem[a + 13'd3], ref_mem[a + 13'd2], b1, b0};
		endcase
	endfunction

	// expected value worked out while the table is built, in table order
	task automatic add_entry(input logic [2:0] t, input access_e acc, input addr_t addr,
			input word_t data);
		entry_t e;
		e.test   = t;
		e.access = acc;
		e.addr   = addr;
		if (is_load(acc)) begin
			e.data     = '0;
			e.exp_data = model_load(acc, addr);
		end else begin
			e.data     = data;
			e.exp_data = '0;
			model_store(acc, addr, data);
		end
		stim.push_back(e);
	endtask

	task automatic build_table();
		// byte stores into each lane of one word
		add_entry(3'd2, acc_sw, 32'h100, next_rand());
		for (int off = 0; off < 4; off++) begin
			add_entry(3'd2, acc_sb, 32'h100 + off, next_rand());
			add_entry(3'd2, acc_lw, 32'h100, '0);
		end
		// halfwords, negative then mixed
		add_entry(3'd3, acc_sw, 32'h200, next_rand() | 32'h8000_8000);
		add_entry(3'd3, acc_lw, 32'h200, '0);
		for (int h = 0; h < 4; h += 2) begin
			add_entry(3'd3, acc_lhu, 32'h200 + h, '0);
			add_entry(3'd3, acc_lh, 32'h200 + h, '0);
		end
		add_entry(3'd3, acc_sh, 32'h200, next_rand() & 32'hffff_7fff);
		add_entry(3'd3, acc_sh, 32'h202, next_rand() | 32'h0000_8000);
		add_entry(3'd3, acc_lw, 32'h200, '0);
		for (int h = 0; h < 4; h += 2) begin
			add_entry(3'd3, acc_lhu, 32'h200 + h, '0);
			add_entry(3'd3, acc_lh, 32'h200 + h, '0);
		end
		// bytes with alternating top bits in the two words
		add_entry(3'd4, acc_sw, 32'h300, (next_rand() | 32'h0080_0080) & 32'h7fff_7fff);
		add_entry(3'd4, acc_sw, 32'h304, (next_rand() | 32'h8000_8000) & 32'hff7f_ff7f);
		for (int b = 0; b < 8; b++) begin
			add_entry(3'd4, acc_lbu, 32'h300 + b, '0);
			add_entry(3'd4, acc_lb, 32'h300 + b, '0);
		end
		// long back-to-back run, longer than the fifo
		for (int k = 0; k < 8; k++) begin
			add_entry(3'd5, acc_sw, 32'h400 + 4 * k, next_rand());
			if (k % 2 == 0) begin
				add_entry(3'd5, acc_lw, 32'h400 + 4 * k, '0);
			end else begin
				add_entry(3'd5, acc_lh, 32'h402 + 4 * k, '0);
			end
		end
		// single loads into an idle unit
		add_entry(3'd6, acc_lw, 32'h100, '0);
		add_entry(3'd6, acc_lbu, 32'h305, '0);
	endtask

	task automatic count_check();
		checks++;
		test_checks++;
	endtask

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic issue_req(input entry_t e);
		req_valid  = 1'b1;
		req.addr   = e.addr;
		req.wdata  = e.data;
		req.access = e.access;
		req.write  = !is_load(e.access);
		// ready only moves on a rising edge
		while (!req_ready) begin
			saw_stall = 1'b1;
			@(negedge clk);
		end
		if (is_load(e.access)) begin
			pending.push_back(e);
		end
		@(negedge clk);
	endtask

	task automatic measure_latency(input entry_t e);
		int lat;
		// let any earlier transfer finish
		repeat (8) @(negedge clk);
		issue_req(e);
		req_valid = 1'b0;
		lat = 1;
		while (!rsp_valid && lat < 4 * load_latency) begin
			@(negedge clk);
			lat++;
		end
		count_check();
		assert (lat == load_latency) else begin
			count_error();
			$display("error at %0t: load response after %0d cycles, expected %0d",
				$time, lat, load_latency);
		end
	endtask

	task automatic apply_test(input logic [2:0] t);
		foreach (stim[i]) begin
			if (stim[i].test == t) begin
				if (t == 3'd6) begin
					measure_latency(stim[i]);
				end else begin
					issue_req(stim[i]);
				end
			end
		end
		req_valid = 1'b0;
		while (pending.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic report_test(input int t, input string name);
		$display("test %0d %s: %0d checks, %0d errors", t, name, test_checks, test_errors);
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// response monitor, in order against the pending loads
	always @(negedge clk) begin
		entry_t e;
		if (!reset && rsp_valid) begin
			count_check();
			assert (pending.size() != 0) else begin
				count_error();
				$display("load response at time %0t with no load outstanding", $time);
			end
			if (pending.size() != 0) begin
				e = pending.pop_front();
				count_check();
				assert (load_data === e.exp_data) else begin
					count_error();
					$display("error at %0t: access %0d at 0x%h gave 0x%h, expected 0x%h",
						$time, e.access, e.addr, load_data, e.exp_data);
				end
			end
		end
	end

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		req_valid   = 1'b0;
		req         = '0;
		rng         = seed;
		checks      = 0;
		errors      = 0;
		test_checks = 0;
		test_errors = 0;
		tests_run   = 0;
		saw_stall   = 1'b0;
		build_table();
		cycle_limit = 8 * stim.size() * 6 + 200;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		count_check();
		assert (req_ready && !rsp_valid) else begin
			count_error();
			$display("error at %0t: after reset req_ready=%b rsp_valid=%b",
				$time, req_ready, rsp_valid);
		end
		report_test(1, "reset state");
		apply_test(3'd2);
		report_test(2, "byte stores");
		apply_test(3'd3);
		report_test(3, "halfword and word");
		apply_test(3'd4);
		report_test(4, "byte loads");
		saw_stall = 1'b0;
		apply_test(3'd5);
		count_check();
		assert (saw_stall) else begin
			count_error();
			$display("req_ready never dropped during the burst");
		end
		report_test(5, "burst");
		apply_test(3'd6);
		report_test(6, "idle latency");
		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- sim/lsu_checker.sv
module lsu_checker import lsu_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  psel,
	input logic  penable,
	input logic  pwrite,
	input addr_t paddr,
	input strb_t pstrb,
	input logic  rd_valid
);

	logic setup_ph;

	assign setup_ph = psel && !penable;

	// access phase entered only straight from setup
	penable_after_setup: assert property (@(posedge clk) disable iff (reset)
		$rose(penable) |-> $past(setup_ph))
		else $error("penable raised without a setup cycle before it");

	// address held from setup into access
	paddr_held: assert property (@(posedge clk) disable iff (reset)
		setup_ph |=> $stable(paddr))
		else $error("paddr changed between setup and access");

	// reads never strobe
	read_strobe_zero: assert property (@(posedge clk) disable iff (reset)
		(psel && !pwrite) |-> (pstrb == '0))
		else $error("pstrb nonzero on a read");

	// sync reset, cleared from the first reset edge on
	no_rd_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> !rd_valid)
		else $error("rd_valid high during reset");

endmodule

bind apb_master lsu_checker i_lsu_checker (
	.clk      (clk),
	.reset    (reset),
	.psel     (psel),
	.penable  (penable),
	.pwrite   (pwrite),
	.paddr    (paddr),
	.pstrb    (pstrb),
	.rd_valid (rd_valid)
);

//--- logic/lsu_top.sv
module lsu_top import lsu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     req_valid,
	input  mem_req_t req,
	output logic     req_ready,
	output logic     rsp_valid,
	output word_t    load_data
);

	// producer to buffer
	logic     push_valid;
	logic     push_ready;
	bus_req_t push_req;
	// buffer to consumer
	logic     pop_valid;
	logic     pop_ready;
	bus_req_t pop_req;
	// APB
	logic     psel;
	logic     penable;
	logic     pwrite;
	addr_t    paddr;
	word_t    pwdata;
	strb_t    pstrb;
	word_t    prdata;
	logic     pready;
	// read return path
	logic     rd_valid;
	rd_rsp_t  rd_rsp;

	lane_steer i_lane_steer (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.push_valid (push_valid),
		.push_req   (push_req),
		.push_ready (push_ready),
		.rd_valid   (rd_valid),
		.rd_rsp     (rd_rsp),
		.rsp_valid  (rsp_valid),
		.load_data  (load_data)
	);

	req_fifo #(
		.depth (fifo_depth_def)
	) i_req_fifo (
		.clk        (clk),
		.reset      (reset),
		.push_valid (push_valid),
		.push_req   (push_req),
		.push_ready (push_ready),
		.pop_valid  (pop_valid),
		.pop_req    (pop_req),
		.pop_ready  (pop_ready)
	);

	apb_master i_apb_master (
		.clk       (clk),
		.reset     (reset),
		.pop_valid (pop_valid),
		.pop_req   (pop_req),
		.pop_ready (pop_ready),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pstrb     (pstrb),
		.prdata    (prdata),
		.pready    (pready),
		.rd_valid  (rd_valid),
		.rd_rsp    (rd_rsp)
	);

	data_sram_apb i_data_sram_apb (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata),
		.pready  (pready)
	);

endmodule

//--- logic/data_sram_apb.sv
module data_sram_apb import lsu_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	// APB completer side
	input  logic  psel,
	input  logic  penable,
	input  logic  pwrite,
	input  addr_t paddr,
	input  word_t pwdata,
	input  strb_t pstrb,
	output word_t prdata,
	output logic  pready
);

	word_t              mem [sram_words];
	logic [sram_aw-1:0] idx;
	logic               setup_ph;
	logic               access_ph;

	// word index, byte offset bits dropped
	assign idx       = paddr[sram_aw+1:2];
	assign setup_ph  = psel && !penable;
	assign access_ph = psel && penable;

	// ready raised for the first access cycle, so no wait states
	always_ff @(posedge clk) begin
		if (reset) begin
			pready <= 1'b0;
		end else begin
			pready <= setup_ph;
		end
	end

	// byte-strobed write during access
	always_ff @(posedge clk) begin
		if (access_ph && pwrite) begin
			for (int b = 0; b < 4; b++) begin
				if (pstrb[b]) begin
					mem[idx][b*8 +: 8] <= pwdata[b*8 +: 8];
				end
			end
		end
	end

	// synchronous read in setup, word valid through the access cycle
	// a write completing just before is already in the array here
	always_ff @(posedge clk) begin
		if (setup_ph) begin
			prdata <= mem[idx];
		end
	end

endmodule

//--- logic/apb_master.sv
module apb_master import lsu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	// from the request FIFO
	input  logic     pop_valid,
	input  bus_req_t pop_req,
	output logic     pop_ready,
	// APB requester side
	output logic     psel,
	output logic     penable,
	output logic     pwrite,
	output addr_t    paddr,
	output word_t    pwdata,
	output strb_t    pstrb,
	input  word_t    prdata,
	input  logic     pready,
	// read word back to lane steering
	output logic     rd_valid,
	output rd_rsp_t  rd_rsp
);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_e;

	state_e   state;
	state_e   state_nxt;
	bus_req_t cur;
	logic     xfer_done;
	logic     take;

	// transfer finishes in access with pready
	assign xfer_done = (state == st_access) && pready;
	// next request can start from idle or straight off a finished access
	assign pop_ready = (state == st_idle) || xfer_done;
	assign take      = pop_valid && pop_ready;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:   if (take) state_nxt = st_setup;
			st_setup:  state_nxt = st_access;
			st_access: begin
				if (pready) begin
					state_nxt = take ? st_setup : st_idle;
				end
			end
			default:   state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// latch request at the setup edge, held until next pop
	always_ff @(posedge clk) begin
		if (take) begin
			cur <= pop_req;
		end
	end

	assign psel    = (state != st_idle);
	assign penable = (state == st_access);
	assign pwrite  = cur.write;
	assign paddr   = cur.word_addr;
	assign pwdata  = cur.wdata;
	// loads already carry a zero strobe
	assign pstrb   = cur.strb;

	// read return, registered one cycle after access
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= xfer_done && !cur.write;
		end
	end

	always_ff @(posedge clk) begin
		if (xfer_done && !cur.write) begin
			rd_rsp.data <= prdata;
			rd_rsp.tag  <= cur.tag;
		end
	end

endmodule

//--- logic/req_fifo.sv
module req_fifo import lsu_pkg::*; #(
	parameter int depth = fifo_depth_def
) (
	input  logic     clk,
	input  logic     reset,
	// write side
	input  logic     push_valid,
	input  bus_req_t push_req,
	output logic     push_ready,
	// read side
	output logic     pop_valid,
	output bus_req_t pop_req,
	input  logic     pop_ready
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	bus_req_t   mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic       do_push;
	logic       do_pop;

	// not full / not empty
	assign push_ready = (count != cnt_w'(depth));
	assign pop_valid  = (count != '0);
	assign pop_req    = mem[rd_ptr];

	assign do_push = push_valid && push_ready;
	assign do_pop  = pop_valid && pop_ready;

	// storage, no reset needed on entries
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_req;
		end
	end

	// pointers wrap at depth, which need not be a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count unchanged
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- logic/lane_steer.sv
module lane_steer import lsu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	// core request side
	input  logic     req_valid,
	input  mem_req_t req,
	output logic     req_ready,
	// into the request FIFO
	output logic     push_valid,
	output bus_req_t push_req,
	input  logic     push_ready,
	// read word back from the APB master
	input  logic     rd_valid,
	input  rd_rsp_t  rd_rsp,
	// load result to the core
	output logic     rsp_valid,
	output word_t    load_data
);

	logic [1:0] req_off;
	word_t      ext_data;

	assign req_off = req.addr[1:0];

	// handshake passes straight through, formatting is combinational
	assign push_valid = req_valid;
	assign req_ready  = push_ready;

	// store formatting
	always_comb begin
		push_req.word_addr  = {req.addr[31:2], 2'b00};
		push_req.write      = req.write;
		push_req.tag.offset = req_off;
		push_req.tag.access = req.access;
		// replicate narrow data so every lane holds it
		case (req.access)
			acc_sb:  push_req.wdata = {4{req.wdata[7:0]}};
			acc_sh:  push_req.wdata = {2{req.wdata[15:0]}};
			default: push_req.wdata = req.wdata;
		endcase
		// strobe from size and offset
		if (!req.write) begin
			push_req.strb = 4'b0000;
		end else begin
			case (req.access)
				acc_sb:  push_req.strb = 4'b0001 << req_off;
				acc_sh:  push_req.strb = req_off[1] ? 4'b1100 : 4'b0011;
				default: push_req.strb = 4'b1111;
			endcase
		end
	end

	// load lane extraction and extension
	always_comb begin
		logic [7:0]  sel_byte;
		logic [15:0] sel_half;
		// byte lane picked by offset
		case (rd_rsp.tag.offset)
			2'd0:    sel_byte = rd_rsp.data[7:0];
			2'd1:    sel_byte = rd_rsp.data[15:8];
			2'd2:    sel_byte = rd_rsp.data[23:16];
			default: sel_byte = rd_rsp.data[31:24];
		endcase
		// halfword lane from bit 1 only
		sel_half = rd_rsp.tag.offset[1] ? rd_rsp.data[31:16] : rd_rsp.data[15:0];
		case (rd_rsp.tag.access)
			acc_lbu: ext_data = {24'h000000, sel_byte};
			acc_lb:  ext_data = {{24{sel_byte[7]}}, sel_byte};
			acc_lhu: ext_data = {16'h0000, sel_half};
			acc_lh:  ext_data = {{16{sel_half[15]}}, sel_half};
			// lw and anything else, whole word
			default: ext_data = rd_rsp.data;
		endcase
	end

	// response valid is control state
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= rd_valid;
		end
	end

	// result word, only loaded on a returning read
	always_ff @(posedge clk) begin
		if (rd_valid) begin
			load_data <= ext_data;
		end
	end

endmodule

//--- logic/lsu_pkg.sv
package lsu_pkg;

	// basic bus widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	// one strobe bit per byte lane
	typedef logic [3:0]  strb_t;

	// access codes, same encoding as the core's DMSel field
	typedef enum logic [2:0] {
		acc_sb  = 3'd0,
		acc_sh  = 3'd1,
		acc_sw  = 3'd2,
		acc_lbu = 3'd3,
		acc_lb  = 3'd4,
		acc_lhu = 3'd5,
		acc_lh  = 3'd6,
		acc_lw  = 3'd7
	} access_e;

	// request as issued by the core
	typedef struct packed {
		addr_t   addr;
		word_t   wdata;
		access_e access;
		logic    write;
	} mem_req_t;

	// what the load path needs to pick the lane on return
	typedef struct packed {
		logic [1:0] offset;
		access_e    access;
	} load_tag_t;

	// formatted request, one FIFO entry
	typedef struct packed {
		// low two bits always zero
		addr_t     word_addr;
		// byte and halfword data replicated over the lanes
		word_t     wdata;
		// zero for loads
		strb_t     strb;
		logic      write;
		load_tag_t tag;
	} bus_req_t;

	// read word coming back from the bus side
	typedef struct packed {
		word_t     data;
		load_tag_t tag;
	} rd_rsp_t;

	// 8 KiB data memory
	localparam int sram_words = 2048;
	localparam int sram_aw    = 11;

	// request buffer depth unless overridden
	localparam int fifo_depth_def = 4;

endpackage
